//--- dwc_macros.svh
// Width macros for the AXI read downsizer, included by the package, the RTL and the testbench
`ifndef DWC_MACROS_SVH
`define DWC_MACROS_SVH

// Byte address width on both ports
`define DWC_ADDR_W 32

// Transaction ID width, same on both ports
`define DWC_ID_W 4

// Slave port faces the wide upstream manager
`define DWC_SLV_DW 64

// Master port faces the narrow memory
`define DWC_MST_DW 32

`endif

//--- dwc_pkg.sv
// Channel structs and enums shared by the downsizer RTL and its testbench
`include "dwc_macros.svh"

package dwc_pkg;

  // AXI burst encodings, 2'b11 is reserved
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_e;

  // Numeric order doubles as severity order
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  // Read request, used on both ports
  typedef struct packed {
    logic [`DWC_ID_W-1:0]   id;
    logic [`DWC_ADDR_W-1:0] addr;
    logic [7:0]             len;
    logic [2:0]             size;
    burst_e                 burst;
  } ar_chan_t;

  // Narrow read beat from the memory
  typedef struct packed {
    logic [`DWC_ID_W-1:0]   id;
    logic [`DWC_MST_DW-1:0] data;
    resp_e                  resp;
    logic                   last;
  } mst_r_chan_t;

  // Wide read beat back to the manager
  typedef struct packed {
    logic [`DWC_ID_W-1:0]   id;
    logic [`DWC_SLV_DW-1:0] data;
    resp_e                  resp;
    logic                   last;
  } slv_r_chan_t;

  // Read controller FSM
  typedef enum logic [1:0] {
    RD_IDLE,    // Waiting for a request
    RD_ISSUE,   // Narrow request on mst_ar
    RD_COLLECT, // Packing narrow beats
    RD_ERROR    // Local SLVERR beats
  } rd_state_e;

endpackage

//--- dwc_ar_xlate.sv
// Combinational check of a wide read request and translation into the narrow master request
`include "dwc_macros.svh"

module dwc_ar_xlate (
  input  dwc_pkg::ar_chan_t req_i,
  output dwc_pkg::ar_chan_t req_o,
  output logic              supported_o
);

  // Byte offset bits inside one beat of each port
  localparam int unsigned slv_off_w = $clog2(`DWC_SLV_DW / 8);
  localparam int unsigned mst_off_w = $clog2(`DWC_MST_DW / 8);
  localparam logic [2:0]  slv_size  = 3'(slv_off_w);
  localparam logic [2:0]  mst_size  = 3'(mst_off_w);

  logic       burst_ok;
  logic       size_ok;
  logic       align_ok;
  logic       len_ok;
  logic [8:0] nar_len;

  // Every wide beat splits into two narrow beats, so len becomes 2*len+1
  assign nar_len = {req_i.len, 1'b0} + 9'd1;

  // Above 128 wide beats the narrow burst would need more than 256 beats
  assign len_ok = ~nar_len[8];

  always_comb begin
    burst_ok = 1'b0;
    case (req_i.burst)
      dwc_pkg::INCR: begin
        burst_ok = 1'b1;
      end
      dwc_pkg::FIXED: begin
        // A single beat FIXED burst is the same as INCR
        burst_ok = (req_i.len == 8'd0);
      end
      default: begin
        burst_ok = 1'b0; // WRAP and reserved
      end
    endcase
  end

  assign size_ok  = (req_i.size == slv_size);                 // Full width only
  assign align_ok = (req_i.addr[slv_off_w-1:0] == '0);        // Low lane comes first

  assign supported_o = burst_ok & size_ok & align_ok & len_ok;

  // Narrow request keeps id and address
  always_comb begin
    req_o       = req_i;
    req_o.len   = nar_len[7:0];
    req_o.size  = mst_size;
    req_o.burst = dwc_pkg::INCR;
  end

endmodule

//--- dwc_r_packer.sv
// Read beat packer that joins narrow beat pairs into wide beats or emits local SLVERR beats
`include "dwc_macros.svh"

module dwc_r_packer (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 start_i,
  input  logic                 err_mode_i,
  input  logic [`DWC_ID_W-1:0] id_i,
  input  logic [7:0]           len_i,
  input  dwc_pkg::mst_r_chan_t mst_r_i,
  input  logic                 mst_r_valid_i,
  output logic                 mst_r_ready_o,
  output dwc_pkg::slv_r_chan_t slv_r_o,
  output logic                 slv_r_valid_o,
  input  logic                 slv_r_ready_i,
  output logic                 done_o
);

  logic                   active_q;
  logic                   err_q;
  logic                   hi_lane_q;  // Next narrow beat is the upper half
  logic                   valid_q;
  logic [7:0]             cnt_q;      // Error beats left after the current one
  logic [`DWC_MST_DW-1:0] lo_data_q;
  dwc_pkg::resp_e         lo_resp_q;
  dwc_pkg::resp_e         worst_resp;
  dwc_pkg::slv_r_chan_t   beat_q;
  logic                   slv_free;
  logic                   mst_hs;
  logic                   slv_hs;

  // Output slot is empty or drains this cycle
  assign slv_free      = ~valid_q | slv_r_ready_i;
  assign mst_r_ready_o = active_q & ~err_q & slv_free;
  assign mst_hs        = mst_r_valid_i & mst_r_ready_o;
  assign slv_hs        = valid_q & slv_r_ready_i;

  assign slv_r_o       = beat_q;
  assign slv_r_valid_o = valid_q;
  assign done_o        = slv_hs & beat_q.last;

  // Worse of the two halves wins
  assign worst_resp = (mst_r_i.resp > lo_resp_q) ? mst_r_i.resp : lo_resp_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q  <= 1'b0;
      err_q     <= 1'b0;
      hi_lane_q <= 1'b0;
      valid_q   <= 1'b0;
      cnt_q     <= 8'd0;
    end else if (start_i) begin
      active_q  <= 1'b1;
      err_q     <= err_mode_i;
      hi_lane_q <= 1'b0;
      valid_q   <= err_mode_i; // First error beat is ready at once
      cnt_q     <= len_i;
    end else begin
      if (done_o) begin
        active_q <= 1'b0;
      end
      if (err_q) begin
        if (slv_hs && beat_q.last) begin
          valid_q <= 1'b0;
        end else if (slv_hs) begin
          cnt_q <= cnt_q - 8'd1;
        end
      end else begin
        if (mst_hs) begin
          hi_lane_q <= ~hi_lane_q;
        end
        if (mst_hs && hi_lane_q) begin
          valid_q <= 1'b1;   // New wide beat replaces the drained one
        end else if (slv_hs) begin
          valid_q <= 1'b0;
        end
      end
    end
  end

  // Beat payload
  always_ff @(posedge clk_i) begin
    if (start_i && err_mode_i) begin
      beat_q <= '{id: id_i, data: '0, resp: dwc_pkg::SLVERR, last: (len_i == 8'd0)};
    end else if (start_i) begin
      beat_q.id <= id_i;
    end else if (err_q) begin
      if (slv_hs) begin
        beat_q.last <= (cnt_q == 8'd1);
      end
    end else if (mst_hs && hi_lane_q) begin
      beat_q.id   <= mst_r_i.id;
      beat_q.data <= {mst_r_i.data, lo_data_q};
      beat_q.resp <= worst_resp;
      beat_q.last <= mst_r_i.last;
    end else if (mst_hs) begin
      lo_data_q <= mst_r_i.data;
      lo_resp_q <= mst_r_i.resp;
    end
  end

endmodule

//--- dwc_read_ctrl.sv
// Read burst FSM that accepts one wide request at a time, issues the narrow request and starts the packer
`include "dwc_macros.svh"

module dwc_read_ctrl (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  dwc_pkg::ar_chan_t    slv_ar_i,
  input  logic                 slv_ar_valid_i,
  output logic                 slv_ar_ready_o,
  output dwc_pkg::ar_chan_t    mst_ar_o,
  output logic                 mst_ar_valid_o,
  input  logic                 mst_ar_ready_i,
  output logic                 pk_start_o,
  output logic                 pk_err_mode_o,
  output logic [`DWC_ID_W-1:0] pk_id_o,
  output logic [7:0]           pk_len_o,
  input  logic                 pk_done_i
);

  dwc_pkg::rd_state_e state_q;
  dwc_pkg::rd_state_e state_d;
  dwc_pkg::ar_chan_t  xlat_req;
  dwc_pkg::ar_chan_t  mst_ar_q;
  logic               xlat_ok;
  logic               accept;

  dwc_ar_xlate u_xlate (
    .req_i      (slv_ar_i),
    .req_o      (xlat_req),
    .supported_o(xlat_ok)
  );

  // Only one burst in flight
  assign slv_ar_ready_o = (state_q == dwc_pkg::RD_IDLE);
  assign accept         = slv_ar_valid_i & slv_ar_ready_o;

  assign mst_ar_valid_o = (state_q == dwc_pkg::RD_ISSUE);
  assign mst_ar_o       = mst_ar_q;

  // Packer is armed in the accept cycle
  assign pk_start_o    = accept;
  assign pk_err_mode_o = ~xlat_ok;
  assign pk_id_o       = slv_ar_i.id;
  assign pk_len_o      = slv_ar_i.len;

  always_comb begin
    state_d = state_q;
    case (state_q)
      dwc_pkg::RD_IDLE: begin
        if (accept && xlat_ok) begin
          state_d = dwc_pkg::RD_ISSUE;
        end else if (accept) begin
          state_d = dwc_pkg::RD_ERROR; // Answered locally, nothing forwarded
        end
      end
      dwc_pkg::RD_ISSUE: begin
        if (mst_ar_ready_i) begin
          state_d = dwc_pkg::RD_COLLECT;
        end
      end
      dwc_pkg::RD_COLLECT,
      dwc_pkg::RD_ERROR: begin
        // Packer signals the last wide beat
        if (pk_done_i) begin
          state_d = dwc_pkg::RD_IDLE;
        end
      end
      default: begin
        state_d = dwc_pkg::RD_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= dwc_pkg::RD_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Narrow request held stable while mst_ar is valid
  always_ff @(posedge clk_i) begin
    if (accept) begin
      mst_ar_q <= xlat_req;
    end
  end

endmodule

//--- dwc_top.sv
// Top level of the 64 to 32 bit AXI read downsizer, joining the controller and the packer
`include "dwc_macros.svh"

module dwc_top (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  // Wide slave port
  input  dwc_pkg::ar_chan_t    slv_ar_i,
  input  logic                 slv_ar_valid_i,
  output logic                 slv_ar_ready_o,
  output dwc_pkg::slv_r_chan_t slv_r_o,
  output logic                 slv_r_valid_o,
  input  logic                 slv_r_ready_i,
  // Narrow master port
  output dwc_pkg::ar_chan_t    mst_ar_o,
  output logic                 mst_ar_valid_o,
  input  logic                 mst_ar_ready_i,
  input  dwc_pkg::mst_r_chan_t mst_r_i,
  input  logic                 mst_r_valid_i,
  output logic                 mst_r_ready_o
);

  logic                 pk_start;
  logic                 pk_err_mode;
  logic [`DWC_ID_W-1:0] pk_id;
  logic [7:0]           pk_len;
  logic                 pk_done;

  dwc_read_ctrl u_ctrl (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .slv_ar_i      (slv_ar_i),
    .slv_ar_valid_i(slv_ar_valid_i),
    .slv_ar_ready_o(slv_ar_ready_o),
    .mst_ar_o      (mst_ar_o),
    .mst_ar_valid_o(mst_ar_valid_o),
    .mst_ar_ready_i(mst_ar_ready_i),
    .pk_start_o    (pk_start),
    .pk_err_mode_o (pk_err_mode),
    .pk_id_o       (pk_id),
    .pk_len_o      (pk_len),
    .pk_done_i     (pk_done)
  );

  dwc_r_packer u_packer (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .start_i      (pk_start),
    .err_mode_i   (pk_err_mode),
    .id_i         (pk_id),
    .len_i        (pk_len),
    .mst_r_i      (mst_r_i),
    .mst_r_valid_i(mst_r_valid_i),
    .mst_r_ready_o(mst_r_ready_o),
    .slv_r_o      (slv_r_o),
    .slv_r_valid_o(slv_r_valid_o),
    .slv_r_ready_i(slv_r_ready_i),
    .done_o       (pk_done)
  );

endmodule

//--- dwc_tb_mem.sv
// Narrow AXI read memory model for the testbench, answers mst_ar bursts with address-based data
`include "dwc_macros.svh"

module dwc_tb_mem (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic [1:0]           rnd_i,      // Random ready and valid gaps
  input  dwc_pkg::ar_chan_t    ar_i,
  input  logic                 ar_valid_i,
  output logic                 ar_ready_o,
  output dwc_pkg::mst_r_chan_t r_o,
  output logic                 r_valid_o,
  input  logic                 r_ready_i
);

  logic                   busy_q;
  logic [`DWC_ID_W-1:0]   id_q;
  logic [`DWC_ADDR_W-1:0] addr_q;  // Address of the beat on r_o
  logic [7:0]             left_q;  // Beats left after this one
  logic                   ar_hs;
  logic                   r_hs;

  assign ar_hs = ar_valid_i & ar_ready_o;
  assign r_hs  = r_valid_o & r_ready_i;

  // Payload only moves on a transfer, so it stays stable under valid
  always_comb begin
    r_o.id   = id_q;
    r_o.data = addr_q ^ 32'hA5A5_0000;
    r_o.resp = addr_q[12] ? dwc_pkg::SLVERR : dwc_pkg::OKAY; // Error region
    r_o.last = (left_q == 8'd0);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q     <= 1'b0;
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
      id_q       <= '0;
      addr_q     <= '0;
      left_q     <= 8'd0;
    end else begin
      if (ar_hs) begin
        busy_q     <= 1'b1;
        ar_ready_o <= 1'b0;
        id_q       <= ar_i.id;
        addr_q     <= ar_i.addr;
        left_q     <= ar_i.len;
      end else if (!busy_q) begin
        ar_ready_o <= rnd_i[0];
      end
      if (r_hs && r_o.last) begin
        r_valid_o <= 1'b0;
        busy_q    <= 1'b0;
      end else if (r_hs) begin
        addr_q    <= addr_q + 32'd4;  // INCR with 4 byte beats
        left_q    <= left_q - 8'd1;
        r_valid_o <= rnd_i[1];
      end else if (busy_q && !r_valid_o) begin
        r_valid_o <= rnd_i[1];
      end
    end
  end

endmodule

//--- dwc_asserts.sv
// Concurrent handshake and ordering assertions, bound into the downsizer top level
module dwc_asserts (
  input logic                 clk_i,
  input logic                 arst_n_i,
  input logic                 slv_ar_valid_i,
  input logic                 slv_ar_ready_o,
  input dwc_pkg::slv_r_chan_t slv_r_o,
  input logic                 slv_r_valid_o,
  input logic                 slv_r_ready_i,
  input dwc_pkg::ar_chan_t    mst_ar_o,
  input logic                 mst_ar_valid_o,
  input logic                 mst_ar_ready_i,
  input logic                 mst_r_ready_o
);

  logic busy_q;  // Burst accepted and last wide beat not yet sent

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
    end else if (slv_ar_valid_i && slv_ar_ready_o) begin
      busy_q <= 1'b1;
    end else if (slv_r_valid_o && slv_r_ready_i && slv_r_o.last) begin
      busy_q <= 1'b0;
    end
  end

  a_slv_r_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    slv_r_valid_o && !slv_r_ready_i |=> slv_r_valid_o && $stable(slv_r_o))
    else $error("slv_r valid or payload changed before ready");

  a_mst_ar_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mst_ar_valid_o && !mst_ar_ready_i |=> mst_ar_valid_o && $stable(mst_ar_o))
    else $error("mst_ar valid or payload changed before ready");

  a_single_burst: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    busy_q |-> !slv_ar_ready_o)
    else $error("slv_ar ready raised while a burst is still open");

  a_hold_low_lane: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    slv_r_valid_o && !slv_r_ready_i |-> !mst_r_ready_o)
    else $error("mst_r ready high while a wide beat is stalled");

endmodule

bind dwc_top dwc_asserts u_asserts (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .slv_ar_valid_i(slv_ar_valid_i),
  .slv_ar_ready_o(slv_ar_ready_o),
  .slv_r_o       (slv_r_o),
  .slv_r_valid_o (slv_r_valid_o),
  .slv_r_ready_i (slv_r_ready_i),
  .mst_ar_o      (mst_ar_o),
  .mst_ar_valid_o(mst_ar_valid_o),
  .mst_ar_ready_i(mst_ar_ready_i),
  .mst_r_ready_o (mst_r_ready_o)
);

//--- dwc_tb.sv
// Testbench top for the read downsizer, run with the file list as top module dwc_tb
`include "dwc_macros.svh"

module dwc_tb;

  logic                 clk_i;
  logic                 arst_n;
  dwc_pkg::ar_chan_t    slv_ar;
  logic                 slv_ar_valid;
  logic                 slv_ar_ready;
  dwc_pkg::slv_r_chan_t slv_r;
  logic                 slv_r_valid;
  logic                 slv_r_ready;
  dwc_pkg::ar_chan_t    mst_ar;
  logic                 mst_ar_valid;
  logic                 mst_ar_ready;
  dwc_pkg::mst_r_chan_t mst_r;
  logic                 mst_r_valid;
  logic                 mst_r_ready;
  logic [1:0]           mem_rnd;

  logic [31:0]       lfsr_q = 32'h1104_a526;
  dwc_pkg::ar_chan_t req_list[$];  // Stimulus in issue order
  dwc_pkg::ar_chan_t req_q[$];     // Accepted and not yet answered
  int                beat_idx = 0;
  logic              ar_seen = 1'b0;
  int                done_cnt = 0;
  int                cycle_limit = 0;
  int                cycles = 0;

  dwc_top dut0 (
    .clk_i(clk_i), .arst_n_i(arst_n),
    .slv_ar_i(slv_ar), .slv_ar_valid_i(slv_ar_valid), .slv_ar_ready_o(slv_ar_ready),
    .slv_r_o(slv_r), .slv_r_valid_o(slv_r_valid), .slv_r_ready_i(slv_r_ready),
    .mst_ar_o(mst_ar), .mst_ar_valid_o(mst_ar_valid), .mst_ar_ready_i(mst_ar_ready),
    .mst_r_i(mst_r), .mst_r_valid_i(mst_r_valid), .mst_r_ready_o(mst_r_ready)
  );

  dwc_tb_mem u_mem (
    .clk_i(clk_i), .arst_n_i(arst_n), .rnd_i(mem_rnd),
    .ar_i(mst_ar), .ar_valid_i(mst_ar_valid), .ar_ready_o(mst_ar_ready),
    .r_o(mst_r), .r_valid_o(mst_r_valid), .r_ready_i(mst_r_ready)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic is_supported(input dwc_pkg::ar_chan_t req);
    logic burst_ok;
    burst_ok = (req.burst == dwc_pkg::INCR) ||
               (req.burst == dwc_pkg::FIXED && req.len == 8'd0);
    return burst_ok && (req.size == 3'd3) && (req.addr[2:0] == 3'd0);
  endfunction

  function automatic dwc_pkg::ar_chan_t ref_mst_ar(input dwc_pkg::ar_chan_t req);
    dwc_pkg::ar_chan_t m;
    m       = req;
    m.len   = {req.len[6:0], 1'b1};  // Two narrow beats per wide beat
    m.size  = 3'd2;
    m.burst = dwc_pkg::INCR;
    return m;
  endfunction

  // Expected wide beat k of a request, low address word in the low half
  function automatic dwc_pkg::slv_r_chan_t ref_beat(input dwc_pkg::ar_chan_t req, input int k);
    dwc_pkg::slv_r_chan_t b;
    logic [31:0]          lo_a;
    logic [31:0]          hi_a;
    b.id   = req.id;
    b.last = (k == int'(req.len));
    lo_a   = req.addr + 32'(8 * k);
    hi_a   = lo_a + 32'd4;
    if (!is_supported(req)) begin
      b.data = '0;
      b.resp = dwc_pkg::SLVERR;
    end else begin
      b.data = {hi_a ^ 32'hA5A5_0000, lo_a ^ 32'hA5A5_0000};
      b.resp = (lo_a[12] || hi_a[12]) ? dwc_pkg::SLVERR : dwc_pkg::OKAY;
    end
    return b;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped after an error");
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got=0x%h exp=0x%h", name, got, exp);
      $display("Done: errors found");
      $fatal(1, "Simulation stopped after an error");
    end
  endtask

  task automatic compare_ar();
    dwc_pkg::ar_chan_t exp;
    if (req_q.size() == 0) begin
      fail_run("mst_ar transfer with no request outstanding");
    end else if (!is_supported(req_q[0])) begin
      fail_run("An unsupported request was forwarded on mst_ar");
    end else if (ar_seen) begin
      fail_run("A second mst_ar transfer was issued for one request");
    end else begin
      exp = ref_mst_ar(req_q[0]);
      check_val("mst_ar.id", mst_ar.id, exp.id);
      check_val("mst_ar.addr", mst_ar.addr, exp.addr);
      check_val("mst_ar.len", mst_ar.len, exp.len);
      check_val("mst_ar.size", mst_ar.size, exp.size);
      check_val("mst_ar.burst", mst_ar.burst, exp.burst);
      ar_seen = 1'b1;
    end
  endtask

  task automatic compare_r();
    dwc_pkg::slv_r_chan_t exp;
    if (req_q.size() == 0) begin
      fail_run("slv_r beat with no request outstanding");
    end else begin
      exp = ref_beat(req_q[0], beat_idx);
      check_val("slv_r.id", slv_r.id, exp.id);
      check_val("slv_r.data", slv_r.data, exp.data);
      check_val("slv_r.resp", slv_r.resp, exp.resp);
      check_val("slv_r.last", slv_r.last, exp.last);
      if (exp.last && is_supported(req_q[0]) && !ar_seen) begin
        fail_run("A supported request returned data without an mst_ar transfer");
      end else if (exp.last) begin
        req_q.delete(0);
        beat_idx = 0;
        ar_seen  = 1'b0;
        done_cnt++;
      end else begin
        beat_idx++;
      end
    end
  endtask

  // Comparison of every transfer, sampled on the edge where it happens
  always @(posedge clk_i) begin
    if (arst_n) begin
      if (slv_ar_valid && slv_ar_ready) req_q.push_back(slv_ar);
      if (mst_ar_valid && mst_ar_ready) compare_ar();
      if (slv_r_valid && slv_r_ready) compare_r();
    end
  end

  // Random back-pressure on slv_r and gaps in the memory
  always @(posedge clk_i) begin
    if (arst_n) begin
      {slv_r_ready, mem_rnd} <= 3'(take_bits(3));
    end
  end

  task automatic queue_request(input logic [`DWC_ID_W-1:0] id,
                               input logic [`DWC_ADDR_W-1:0] addr, input logic [7:0] len,
                               input logic [2:0] size, input dwc_pkg::burst_e burst);
    dwc_pkg::ar_chan_t r;
    r = '{id: id, addr: addr, len: len, size: size, burst: burst};
    req_list.push_back(r);
    cycle_limit += 40 * (int'(len) + 1);
  endtask

  task automatic send_req(input dwc_pkg::ar_chan_t req);
    slv_ar       <= req;
    slv_ar_valid <= 1'b1;
    @(posedge clk_i);
    while (!slv_ar_ready) @(posedge clk_i);
  endtask

  initial begin
    slv_ar       = '0;
    slv_ar_valid = 1'b0;
    slv_r_ready  = 1'b0;
    mem_rnd      = 2'b00;
    arst_n       = 1'b0;
    queue_request(4'h1, 32'h0000_0100, 8'd0, 3'd3, dwc_pkg::INCR);
    queue_request(4'h2, 32'h0000_0200, 8'd3, 3'd3, dwc_pkg::INCR);
    queue_request(4'h3, 32'h0000_0400, 8'd15, 3'd3, dwc_pkg::INCR);
    queue_request(4'h4, 32'h0000_0800, 8'd0, 3'd3, dwc_pkg::FIXED);
    queue_request(4'h5, 32'h0000_0300, 8'd3, 3'd3, dwc_pkg::WRAP);
    queue_request(4'h6, 32'h0000_0340, 8'd2, 3'd3, dwc_pkg::FIXED);
    queue_request(4'h7, 32'h0000_0380, 8'd1, 3'd2, dwc_pkg::INCR);   // Narrow size
    queue_request(4'h8, 32'h0000_0384, 8'd1, 3'd3, dwc_pkg::INCR);   // Unaligned
    queue_request(4'h9, 32'h0000_0FE0, 8'd7, 3'd3, dwc_pkg::INCR);   // Into error region
    queue_request(4'hA, 32'h0000_1FF0, 8'd3, 3'd3, dwc_pkg::INCR);   // Out of error region
    for (int i = 0; i < 6; i++) begin
      queue_request(4'(take_bits(4)), 32'h0000_0F00 + {21'd0, 8'(take_bits(8)), 3'd0},
                    8'(take_bits(3)), 3'd3,
                    (take_bits(2) == 0) ? dwc_pkg::WRAP : dwc_pkg::INCR);
    end
    cycle_limit += 10;  // Reset time
    repeat (10) @(posedge clk_i);
    arst_n <= 1'b1;
    foreach (req_list[i]) begin
      send_req(req_list[i]);
    end
    slv_ar_valid <= 1'b0;
    while (done_cnt < req_list.size()) @(posedge clk_i);
    $display("Done: no errors");
    $finish;
  end

  initial begin
    @(posedge clk_i);
    while (cycles <= cycle_limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: the run hung and not all bursts were answered");
    $display("Done: errors found");
    $fatal(1, "Simulation stopped on timeout");
  end

endmodule

//--- dwc.f
+incdir+.
dwc_pkg.sv
dwc_ar_xlate.sv
dwc_r_packer.sv
dwc_read_ctrl.sv
dwc_top.sv
dwc_tb_mem.sv
dwc_asserts.sv
dwc_tb.sv
